/* tb.f */
source/axi_types_pkg.sv
source/router_cfg_pkg.sv
source/route_fifo.sv
source/router_channel.sv
source/router_command.sv
source/axi_router_wr.sv
sim/tb_axi_router_wr.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_axi_router_wr -f tb.f --Mdir obj_dir \
    && ./obj_dir/Vtb_axi_router_wr > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

/* sim/tb_axi_router_wr.sv */
module tb_axi_router_wr;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_types_pkg::*;
    import router_cfg_pkg::*;

    localparam int ROWS  = 8;
    localparam int LIMIT = 40 * ROWS + 100;    // cycles

    typedef struct packed {
        in_idx_t     port;
        addr_t       addr;      // bits 11:8 carry the row number
        len_t        len;
        data_t       seed;
        resp_t       resp;
        logic [15:0] start;     // earliest cycle for the AW
    } row_t;

    row_t rows [ROWS] = '{
        '{1'b0, 32'h0000_0000, 4'd3, 32'h0000_1000, 2'd0, 16'd8},
        '{1'b1, 32'h1000_0100, 4'd1, 32'h0000_2000, 2'd2, 16'd8},
        '{1'b0, 32'h1000_0200, 4'd0, 32'h0000_3000, 2'd1, 16'd8},
        '{1'b1, 32'h0000_0300, 4'd2, 32'h0000_4000, 2'd0, 16'd8},
        '{1'b0, 32'h2000_0400, 4'd2, 32'h0000_5000, 2'd3, 16'd40},  // unmapped
        '{1'b1, 32'h1000_0500, 4'd4, 32'h0000_6000, 2'd0, 16'd40},
        '{1'b0, 32'h0000_0600, 4'd7, 32'h0000_7000, 2'd2, 16'd80},
        '{1'b1, 32'h0000_0700, 4'd3, 32'h0000_8000, 2'd1, 16'd80}
    };

    logic                          clk = 1'b0;
    logic                          arst_n;
    aw_cmd_t [INPUTS-1:0]          in_aw;
    logic [INPUTS-1:0]             in_aw_valid;
    logic [INPUTS-1:0]             in_aw_ready;
    w_beat_t [INPUTS-1:0]          in_w;
    logic [INPUTS-1:0]             in_w_valid;
    logic [INPUTS-1:0]             in_w_ready;
    b_rsp_t [INPUTS-1:0]           in_b;
    logic [INPUTS-1:0]             in_b_valid;
    logic [INPUTS-1:0]             in_b_ready;
    aw_cmd_t [OUTPUTS-1:0]         out_aw;
    logic [OUTPUTS-1:0]            out_aw_valid;
    logic [OUTPUTS-1:0]            out_aw_ready;
    w_beat_t [OUTPUTS-1:0]         out_w;
    logic [OUTPUTS-1:0]            out_w_valid;
    logic [OUTPUTS-1:0]            out_w_ready;
    b_rsp_t [OUTPUTS-1:0]          out_b;
    logic [OUTPUTS-1:0]            out_b_valid;
    logic [OUTPUTS-1:0]            out_b_ready;

    int          cycle = 0;
    int          rows_done = 0;
    int          checks = 0;
    int          errors = 0;
    int          row_errs [ROWS] = '{default: 0};
    int          aw_seen [ROWS] = '{default: 0};     // commands seen per row
    int          b_seen [INPUTS] = '{default: 0};    // responses taken per input
    integer      seed = 32'haed2_4ae1;
    logic [31:0] rnd = '0;          // stall bits for the slaves

    always #2 clk = ~clk;

    always @(negedge clk) rnd <= $random(seed);

    axi_router_wr DUT (.*);

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // window rule, anything else lands on the last output
    function automatic out_idx_t expect_port(addr_t addr);
        if ((addr & 32'hF000_0000) == 32'h0000_0000) return out_idx_t'(0);
        if ((addr & 32'hF000_0000) == 32'h1000_0000) return out_idx_t'(1);
        return out_idx_t'(OUTPUTS - 1);
    endfunction

    task automatic report(int row, string name, logic bad, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (bad) begin
            $display("Error at %0t: %s got %0h, expected %0h", $time, name, got, exp);
            errors++;
            if (row >= 0) row_errs[row]++;
        end
    endtask

    task automatic check_addr(int row, string name, addr_t got, addr_t exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask
    task automatic check_len(int row, string name, len_t got, len_t exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask
    task automatic check_data(int row, string name, data_t got, data_t exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask
    task automatic check_strb(int row, string name, strb_t got, strb_t exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask
    task automatic check_resp(int row, string name, resp_t got, resp_t exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask
    task automatic check_port(int row, string name, out_idx_t got, out_idx_t exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask
    task automatic check_flag(int row, string name, logic got, logic exp);
        report(row, name, got !== exp, 64'(got), 64'(exp));
    endtask

    for (genvar j = 0; j < INPUTS; j++) begin : g_master
        aw_cmd_t aw;
        logic    aw_valid;
        w_beat_t w;
        logic    w_valid;

        assign in_aw[j]       = aw;
        assign in_aw_valid[j] = aw_valid;
        assign in_w[j]        = w;
        assign in_w_valid[j]  = w_valid;
        assign in_b_ready[j]  = 1'b1;

        // chan 0 aw, 1 w, 2 b
        task automatic wait_transfer(int chan, int r);
            logic done;
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                case (chan)
                    0:       done = in_aw_ready[j];
                    1:       done = in_w_ready[j];
                    default: done = in_b_valid[j];
                endcase
                if (done && chan == 2) check_resp(r, "in_b.resp", in_b[j].resp, rows[r].resp);
                next_cycle();
            end
        endtask

        task automatic run_row(int r);
            row_t row;
            row = rows[r];
            while (cycle < int'(row.start)) next_cycle();
            aw       = '{addr: row.addr, len: row.len};
            aw_valid = 1'b1;
            wait_transfer(0, r);
            aw_valid = 1'b0;
            for (int b = 0; b <= int'(row.len); b++) begin    // burst right after AW
                w.data  = row.seed + data_t'(b);
                w.strb  = (r % 2 == 1) ? strb_t'(4'h3) : '1;
                w.last  = (b == int'(row.len));
                w_valid = 1'b1;
                wait_transfer(1, r);
            end
            w_valid = 1'b0;
            wait_transfer(2, r);
            $display("row %0d: input %0d, addr %h, %0d beats, %s", r, j, row.addr,
                     int'(row.len) + 1, (row_errs[r] == 0) ? "ok" : "FAILED");
            rows_done++;
        endtask

        initial begin
            aw       = '0;
            aw_valid = 1'b0;
            w        = '0;
            w_valid  = 1'b0;
            wait (arst_n === 1'b1);
            next_cycle();
            for (int r = 0; r < ROWS; r++) begin
                if (rows[r].port == in_idx_t'(j)) run_row(r);
            end
        end
    end

    for (genvar k = 0; k < OUTPUTS; k++) begin : g_slave
        logic   aw_ready;
        logic   w_ready;
        logic   b_valid;
        b_rsp_t b;
        int     aw_q [$];      // rows in AW order
        int     b_q [$];       // rows owed a response
        int     beat;

        assign out_aw_ready[k] = aw_ready;
        assign out_w_ready[k]  = w_ready;
        assign out_b_valid[k]  = b_valid;
        assign out_b[k]        = b;

        initial begin
            int r;
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            b_valid  = 1'b0;
            b        = '0;
            beat     = 0;
            wait (arst_n === 1'b1);
            forever begin
                next_cycle();
                aw_ready = |rnd[2*k +: 2];
                w_ready  = (|rnd[4 + 2*k +: 2]) && (aw_q.size() > 0);   // W only after its AW
                b_valid  = (b_q.size() > 0);
                if (b_valid) b.resp = rows[b_q[0]].resp;
                @(negedge clk);
                if (out_aw_valid[k] && aw_ready) begin
                    r = int'(out_aw[k].addr[11:8]);
                    if (r >= ROWS) begin
                        $display("unexpected command at output %0d, addr %h", k, out_aw[k].addr);
                        errors++;
                    end else begin
                        check_port(r, "out_aw port", out_idx_t'(k), expect_port(rows[r].addr));
                        check_addr(r, "out_aw.addr", out_aw[k].addr, rows[r].addr);
                        check_len(r, "out_aw.len", out_aw[k].len, rows[r].len);
                        aw_seen[r]++;
                        aw_q.push_back(r);
                    end
                end
                if (out_w_valid[k] && w_ready) begin
                    r = aw_q[0];
                    check_data(r, "out_w.data", out_w[k].data, rows[r].seed + data_t'(beat));
                    check_strb(r, "out_w.strb", out_w[k].strb,
                               (r % 2 == 1) ? strb_t'(4'h3) : '1);
                    check_flag(r, "out_w.last", out_w[k].last, beat == int'(rows[r].len));
                    beat++;
                    if (out_w[k].last) begin
                        beat = 0;
                        void'(aw_q.pop_front());
                        b_q.push_back(r);
                    end
                end
                if (b_valid && out_b_ready[k]) void'(b_q.pop_front());
            end
        end
    end

    // every response handed to a master, wanted or not
    always @(negedge clk) begin
        for (int j = 0; j < INPUTS; j++) begin
            if (in_b_valid[j] && in_b_ready[j]) begin
                b_seen[j]++;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d rows finished", cycle, rows_done, ROWS);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int owed;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_flag(-1, "out_aw_valid", |out_aw_valid, 1'b0);
        check_flag(-1, "out_w_valid", |out_w_valid, 1'b0);
        check_flag(-1, "out_b_ready", |out_b_ready, 1'b0);
        check_flag(-1, "in_w_ready", |in_w_ready, 1'b0);
        check_flag(-1, "in_b_valid", |in_b_valid, 1'b0);
        check_flag(-1, "in_aw_ready", &in_aw_ready, 1'b1);
        wait (rows_done == ROWS);
        repeat (4) next_cycle();
        @(negedge clk);
        for (int r = 0; r < ROWS; r++) begin
            checks++;
            if (aw_seen[r] != 1) begin
                $display("row %0d: command reached the outputs %0d times", r, aw_seen[r]);
                errors++;
            end
        end
        for (int j = 0; j < INPUTS; j++) begin
            owed = 0;
            for (int r = 0; r < ROWS; r++) begin
                if (rows[r].port == in_idx_t'(j)) owed++;
            end
            checks++;
            if (b_seen[j] != owed) begin
                $display("input %0d took %0d responses for %0d commands", j, b_seen[j], owed);
                errors++;
            end
        end
        $display("%0d rows, %0d checks, %0d errors", rows_done, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* source/axi_router_wr.sv */
module axi_router_wr (
    input  logic                                                 clk,
    input  logic                                                 arst_n,

    // masters
    input  axi_types_pkg::aw_cmd_t [router_cfg_pkg::INPUTS-1:0]  in_aw,
    input  logic [router_cfg_pkg::INPUTS-1:0]                    in_aw_valid,
    output logic [router_cfg_pkg::INPUTS-1:0]                    in_aw_ready,
    input  axi_types_pkg::w_beat_t [router_cfg_pkg::INPUTS-1:0]  in_w,
    input  logic [router_cfg_pkg::INPUTS-1:0]                    in_w_valid,
    output logic [router_cfg_pkg::INPUTS-1:0]                    in_w_ready,
    output axi_types_pkg::b_rsp_t [router_cfg_pkg::INPUTS-1:0]   in_b,
    output logic [router_cfg_pkg::INPUTS-1:0]                    in_b_valid,
    input  logic [router_cfg_pkg::INPUTS-1:0]                    in_b_ready,

    // slaves
    output axi_types_pkg::aw_cmd_t [router_cfg_pkg::OUTPUTS-1:0] out_aw,
    output logic [router_cfg_pkg::OUTPUTS-1:0]                   out_aw_valid,
    input  logic [router_cfg_pkg::OUTPUTS-1:0]                   out_aw_ready,
    output axi_types_pkg::w_beat_t [router_cfg_pkg::OUTPUTS-1:0] out_w,
    output logic [router_cfg_pkg::OUTPUTS-1:0]                   out_w_valid,
    input  logic [router_cfg_pkg::OUTPUTS-1:0]                   out_w_ready,
    input  axi_types_pkg::b_rsp_t [router_cfg_pkg::OUTPUTS-1:0]  out_b,
    input  logic [router_cfg_pkg::OUTPUTS-1:0]                   out_b_valid,
    output logic [router_cfg_pkg::OUTPUTS-1:0]                   out_b_ready
);
    import axi_types_pkg::*;
    import router_cfg_pkg::*;

    logic                                   cmd_push;
    in_idx_t                                cmd_in;
    out_idx_t                               cmd_out;
    logic [INPUTS-1:0]                      w_full_src;
    logic [OUTPUTS-1:0]                     w_full_snk;
    logic [OUTPUTS-1:0]                     b_full_src;
    logic [INPUTS-1:0]                      b_full_snk;
    logic [INPUTS-1:0][DATA_W+STRB_W-1:0]   w_src_data;  // {strb, data}
    logic [INPUTS-1:0]                      w_src_last;
    logic [OUTPUTS-1:0][DATA_W+STRB_W-1:0]  w_snk_data;
    logic [OUTPUTS-1:0]                     w_snk_last;

    router_command u_command (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_aw        (in_aw),
        .in_aw_valid  (in_aw_valid),
        .in_aw_ready  (in_aw_ready),
        .out_aw       (out_aw),
        .out_aw_valid (out_aw_valid),
        .out_aw_ready (out_aw_ready),
        .full_in      (w_full_src | b_full_snk),
        .full_out     (w_full_snk | b_full_src),
        .cmd_push     (cmd_push),
        .cmd_in       (cmd_in),
        .cmd_out      (cmd_out)
    );

    for (genvar j = 0; j < INPUTS; j++) begin : g_w_in
        assign w_src_data[j] = {in_w[j].strb, in_w[j].data};
        assign w_src_last[j] = in_w[j].last;
    end

    for (genvar k = 0; k < OUTPUTS; k++) begin : g_w_out
        assign {out_w[k].strb, out_w[k].data} = w_snk_data[k];
        assign out_w[k].last                  = w_snk_last[k];
    end

    // write data, masters to slaves
    router_channel #(
        .WIDTH     (DATA_W + STRB_W),
        .SOURCES   (INPUTS),
        .SINKS     (OUTPUTS),
        .BURST     (1)
    ) u_w_channel (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_push  (cmd_push),
        .cmd_src   (cmd_in),
        .cmd_snk   (cmd_out),
        .full_src  (w_full_src),
        .full_snk  (w_full_snk),
        .src_data  (w_src_data),
        .src_last  (w_src_last),
        .src_valid (in_w_valid),
        .src_ready (in_w_ready),
        .snk_data  (w_snk_data),
        .snk_last  (w_snk_last),
        .snk_valid (out_w_valid),
        .snk_ready (out_w_ready)
    );

    // responses, slaves back to masters
    router_channel #(
        .WIDTH     ($bits(b_rsp_t)),
        .SOURCES   (OUTPUTS),
        .SINKS     (INPUTS),
        .BURST     (0)
    ) u_b_channel (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_push  (cmd_push),
        .cmd_src   (cmd_out),
        .cmd_snk   (cmd_in),
        .full_src  (b_full_src),
        .full_snk  (b_full_snk),
        .src_data  (out_b),
        .src_last  ('1),
        .src_valid (out_b_valid),
        .src_ready (out_b_ready),
        .snk_data  (in_b),
        .snk_last  (),
        .snk_valid (in_b_valid),
        .snk_ready (in_b_ready)
    );

endmodule

/* source/router_command.sv */
module router_command (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  axi_types_pkg::aw_cmd_t [router_cfg_pkg::INPUTS-1:0]  in_aw,
    input  logic [router_cfg_pkg::INPUTS-1:0]                   in_aw_valid,
    output logic [router_cfg_pkg::INPUTS-1:0]                   in_aw_ready,
    output axi_types_pkg::aw_cmd_t [router_cfg_pkg::OUTPUTS-1:0] out_aw,
    output logic [router_cfg_pkg::OUTPUTS-1:0]                  out_aw_valid,
    input  logic [router_cfg_pkg::OUTPUTS-1:0]                  out_aw_ready,
    input  logic [router_cfg_pkg::INPUTS-1:0]                   full_in,
    input  logic [router_cfg_pkg::OUTPUTS-1:0]                  full_out,
    output logic                                                cmd_push,
    output router_cfg_pkg::in_idx_t                             cmd_in,
    output router_cfg_pkg::out_idx_t                            cmd_out
);
    import axi_types_pkg::*;
    import router_cfg_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_HOLD
    } state_t;

    state_t                  state;
    in_idx_t                 rr_ptr;        // last winner
    in_idx_t                 grant_idx;
    logic                    grant_found;
    out_idx_t [INPUTS-1:0]   dec_out;
    logic [INPUTS-1:0]       blocked;
    aw_cmd_t                 hold_aw;
    out_idx_t                hold_out;
    logic                    draining;
    logic                    can_accept;
    logic                    accept;

    // lowest matching window wins
    function automatic out_idx_t decode(addr_t addr);
        out_idx_t sel;
        sel = out_idx_t'(OUTPUTS - 1);
        for (int k = OUTPUTS - 1; k >= 0; k--) begin
            if ((addr & MASKS[k]) == BASES[k]) begin
                sel = out_idx_t'(k);
            end
        end
        return sel;
    endfunction

    always_comb begin
        for (int j = 0; j < INPUTS; j++) begin
            dec_out[j] = decode(in_aw[j].addr);
            blocked[j] = full_in[j] | full_out[dec_out[j]];   // either channel full
        end
    end

    // round robin, search starts after the last winner
    always_comb begin : arb
        in_idx_t cand;
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        cand        = rr_ptr;
        for (int i = 1; i <= INPUTS; i++) begin
            cand = in_idx_t'((int'(rr_ptr) + i) % INPUTS);
            if (!grant_found && in_aw_valid[cand] && !blocked[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    assign draining   = (state == ST_HOLD) && out_aw_ready[hold_out];
    assign can_accept = (state == ST_IDLE) || draining;

    always_comb begin
        for (int j = 0; j < INPUTS; j++) begin
            in_aw_ready[j] = can_accept && !blocked[j]
                             && (!grant_found || grant_idx == in_idx_t'(j));
        end
    end

    assign accept   = |(in_aw_valid & in_aw_ready);
    assign cmd_push = accept;
    assign cmd_in   = grant_idx;
    assign cmd_out  = dec_out[grant_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            rr_ptr   <= in_idx_t'(INPUTS - 1);    // input 0 goes first
            hold_out <= '0;
        end else if (accept) begin
            state    <= ST_HOLD;
            rr_ptr   <= grant_idx;
            hold_out <= cmd_out;
        end else if (draining) begin
            state <= ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_aw <= in_aw[grant_idx];
        end
    end

    always_comb begin
        for (int k = 0; k < OUTPUTS; k++) begin
            out_aw[k]       = hold_aw;        // only the valid one matters
            out_aw_valid[k] = (state == ST_HOLD) && (hold_out == out_idx_t'(k));
        end
    end

    // at most one input wins per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(in_aw_valid & in_aw_ready))
        else $error("router_command: more than one input accepted");

    // a master keeps a stalled command in place
    for (genvar j = 0; j < INPUTS; j++) begin : g_in_hold
        a_in_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
            in_aw_valid[j] && !in_aw_ready[j] |=> in_aw_valid[j] && $stable(in_aw[j]))
            else $error("router_command: input %0d dropped a stalled command", j);
    end

endmodule

/* source/router_channel.sv */
module router_channel #(
    parameter int WIDTH   = 8,      // payload bits
    parameter int SOURCES = 2,
    parameter int SINKS   = 2,
    parameter int BURST   = 1       // 0: every beat is final
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           cmd_push,
    input  logic [$clog2(SOURCES)-1:0]     cmd_src,
    input  logic [$clog2(SINKS)-1:0]       cmd_snk,
    output logic [SOURCES-1:0]             full_src,
    output logic [SINKS-1:0]               full_snk,
    input  logic [SOURCES-1:0][WIDTH-1:0]  src_data,
    input  logic [SOURCES-1:0]             src_last,
    input  logic [SOURCES-1:0]             src_valid,
    output logic [SOURCES-1:0]             src_ready,
    output logic [SINKS-1:0][WIDTH-1:0]    snk_data,
    output logic [SINKS-1:0]               snk_last,
    output logic [SINKS-1:0]               snk_valid,
    input  logic [SINKS-1:0]               snk_ready
);
    typedef logic [$clog2(SOURCES)-1:0] src_idx_t;
    typedef logic [$clog2(SINKS)-1:0]   snk_idx_t;

    snk_idx_t [SOURCES-1:0] src_head;      // sink each source feeds next
    src_idx_t [SINKS-1:0]   snk_head;      // source each sink waits on
    logic [SOURCES-1:0]     src_empty;
    logic [SOURCES-1:0]     src_match;
    logic [SOURCES-1:0]     src_final;
    logic [SOURCES-1:0]     src_pop;
    logic [SINKS-1:0]       snk_empty;
    logic [SINKS-1:0]       snk_match;
    logic [SINKS-1:0]       snk_pop;

    for (genvar s = 0; s < SOURCES; s++) begin : g_src_q
        route_fifo #(
            .WIDTH     ($bits(snk_idx_t))
        ) u_src_q (
            .clk       (clk),
            .arst_n    (arst_n),
            .push      (cmd_push && (cmd_src == src_idx_t'(s))),
            .push_data (cmd_snk),
            .pop       (src_pop[s]),
            .head      (src_head[s]),
            .full      (full_src[s]),
            .empty     (src_empty[s])
        );
    end

    for (genvar k = 0; k < SINKS; k++) begin : g_snk_q
        route_fifo #(
            .WIDTH     ($bits(src_idx_t))
        ) u_snk_q (
            .clk       (clk),
            .arst_n    (arst_n),
            .push      (cmd_push && (cmd_snk == snk_idx_t'(k))),
            .push_data (cmd_src),
            .pop       (snk_pop[k]),
            .head      (snk_head[k]),
            .full      (full_snk[k]),
            .empty     (snk_empty[k])
        );
    end

    assign src_final = (BURST != 0) ? src_last : '1;

    // source side, both heads must name each other
    always_comb begin
        for (int s = 0; s < SOURCES; s++) begin
            src_match[s] = !src_empty[s] && !snk_empty[src_head[s]]
                           && (snk_head[src_head[s]] == src_idx_t'(s));
            src_ready[s] = src_match[s] && snk_ready[src_head[s]];
            src_pop[s]   = src_valid[s] && src_ready[s] && src_final[s];
        end
    end

    // sink side, same pairing seen from the other end
    always_comb begin
        for (int k = 0; k < SINKS; k++) begin
            snk_match[k] = !snk_empty[k] && !src_empty[snk_head[k]]
                           && (src_head[snk_head[k]] == snk_idx_t'(k));
            snk_valid[k] = snk_match[k] && src_valid[snk_head[k]];
            snk_data[k]  = src_data[snk_head[k]];
            snk_last[k]  = src_final[snk_head[k]];
            snk_pop[k]   = snk_valid[k] && snk_ready[k] && snk_last[k];
        end
    end

    // a beat may only show up once its command has been routed
    a_src_queued: assert property (@(posedge clk) disable iff (!arst_n)
        (src_valid & src_empty) == '0)
        else $error("router_channel: source valid without a queued command");

endmodule

/* source/route_fifo.sv */
module route_fifo #(
    parameter int WIDTH = $bits(router_cfg_pkg::out_idx_t)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             full,
    output logic             empty
);
    import router_cfg_pkg::*;

    typedef logic [$clog2(MOT)-1:0]   ptr_t;
    typedef logic [$clog2(MOT+1)-1:0] cnt_t;

    logic [WIDTH-1:0] mem [MOT];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    cnt_t             count;

    assign head  = mem[rd_ptr];
    assign full  = (count == cnt_t'(MOT));
    assign empty = (count == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(MOT - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(MOT - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_t'(push) - cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // command side must hold off on full, channel side never pops ahead
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else $error("route_fifo: push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else $error("route_fifo: pop while empty");

endmodule

/* source/router_cfg_pkg.sv */
package router_cfg_pkg;

    localparam int INPUTS  = 2;     // master ports
    localparam int OUTPUTS = 2;     // slave ports

    // order queue depth per port
    localparam int MOT = 4;

    typedef logic [$clog2(INPUTS)-1:0]  in_idx_t;
    typedef logic [$clog2(OUTPUTS)-1:0] out_idx_t;

    // hit when (addr & mask) == base
    // no hit at all goes to the last output
    localparam axi_types_pkg::addr_t BASES [OUTPUTS] = '{
        32'h0000_0000,
        32'h1000_0000
    };

    localparam axi_types_pkg::addr_t MASKS [OUTPUTS] = '{
        32'hF000_0000,
        32'hF000_0000
    };

endpackage

/* source/axi_types_pkg.sv */
package axi_types_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;     // one per byte
    localparam int LEN_W  = 4;              // beats = len + 1

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    // write command
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } aw_cmd_t;

    // one write beat
    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    // write response, no id
    typedef struct packed {
        resp_t resp;
    } b_rsp_t;

endpackage
